// ==== common/gat_pkg.sv ====
package gat_pkg;

  // Feature sizes
  localparam int DATA_WIDTH      = 8;
  localparam int NUM_FEATURE_IN  = 16;
  localparam int NUM_FEATURE_OUT = 4;
  localparam int COL_IDX_WIDTH   = $clog2(NUM_FEATURE_IN);
  localparam int FEAT_IDX_WIDTH  = $clog2(NUM_FEATURE_OUT);

  // Config address is {row, feature} for weights
  localparam int CFG_ADDR_WIDTH  = COL_IDX_WIDTH + FEAT_IDX_WIDTH;

  // Wide enough for a full sparse row dot product
  localparam int WH_DATA_WIDTH   = 20;
  localparam int COEF_WIDTH      = 32;

  typedef logic signed [DATA_WIDTH-1:0]    data_t;
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_t;
  typedef logic signed [COEF_WIDTH-1:0]    coef_t;

  // One row of W, also used for each half of the attention vector
  typedef data_t [NUM_FEATURE_OUT-1:0] wgt_row_t;

  typedef wh_t [NUM_FEATURE_OUT-1:0] wh_vec_t;

  typedef enum logic {
    CFG_WEIGHT = 1'b0,
    CFG_ATTN   = 1'b1
  } cfg_target_e;

  // Input stream entry
  typedef struct packed {
    data_t                    value;
    logic [COL_IDX_WIDTH-1:0] col_idx;
    logic                     row_last;
    logic                     subgraph_first;
  } sparse_entry_t;

  // Finished Wh row, centre marks the first node of a subgraph
  typedef struct packed {
    wh_vec_t wh;
    logic    centre;
  } wh_row_t;

  typedef struct packed {
    wh_vec_t wh;
    coef_t   coef;
  } gat_out_t;

endpackage

// ==== verilog/weight_store.sv ====
`timescale 1ns/1ps

module weight_store
  import gat_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      cfg_we_i,
  input  cfg_target_e               cfg_target_i,
  input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr_i,
  input  data_t                     cfg_data_i,

  input  logic                      rd_en_i,
  input  logic [COL_IDX_WIDTH-1:0]  rd_col_i,
  output wgt_row_t                  wgt_row_o,

  output wgt_row_t                  a_self_o,
  output wgt_row_t                  a_neigh_o
);

  wgt_row_t w_mem [NUM_FEATURE_IN];

  logic [COL_IDX_WIDTH-1:0]  cfg_row;
  logic [FEAT_IDX_WIDTH-1:0] cfg_feat;

  assign cfg_row  = cfg_addr_i[CFG_ADDR_WIDTH-1:FEAT_IDX_WIDTH];
  assign cfg_feat = cfg_addr_i[FEAT_IDX_WIDTH-1:0];

  // Weight array and registered read port
  always_ff @(posedge clk) begin
    if (cfg_we_i && cfg_target_i == CFG_WEIGHT) begin
      w_mem[cfg_row][cfg_feat] <= cfg_data_i;
    end
    if (rd_en_i) begin
      wgt_row_o <= w_mem[rd_col_i];
    end
  end

  // Attention vector, upper half of the index space is a_neigh
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_self_o  <= '0;
      a_neigh_o <= '0;
    end else if (cfg_we_i && cfg_target_i == CFG_ATTN) begin
      if (cfg_addr_i[FEAT_IDX_WIDTH]) begin
        a_neigh_o[cfg_feat] <= cfg_data_i;
      end else begin
        a_self_o[cfg_feat] <= cfg_data_i;
      end
    end
  end

  // Host must finish configuration before streaming rows
  assert property (@(posedge clk) disable iff (!rst_n) !(cfg_we_i && rd_en_i))
    else $error("weight_store: configuration write during row stream");

endmodule

// ==== spmm/spmm_row.sv ====
`timescale 1ns/1ps

module spmm_row
  import gat_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,

  input  logic          h_vld_i,
  input  sparse_entry_t h_i,
  input  wgt_row_t      wgt_row_i,

  output logic          row_vld_o,
  output wh_row_t       row_o
);

  // Entry delayed by one cycle to meet its weight row
  sparse_entry_t ent_q;
  logic          ent_vld_q;

  wh_vec_t acc_q;
  wh_vec_t acc_sum;
  logic    row_done;

  assign row_done = ent_vld_q && ent_q.row_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_vld_q <= 1'b0;
    end else begin
      ent_vld_q <= h_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (h_vld_i) begin
      ent_q <= h_i;
    end
  end

  // value x weight row added per output feature
  always_comb begin
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      acc_sum[k] = acc_q[k] + wh_t'(ent_q.value) * wh_t'(wgt_row_i[k]);
    end
  end

  // Clear on the last entry so the next row starts from zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (ent_vld_q) begin
      acc_q <= ent_q.row_last ? '0 : acc_sum;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_vld_o <= 1'b0;
    end else begin
      row_vld_o <= row_done;
    end
  end

  always_ff @(posedge clk) begin
    if (row_done) begin
      row_o.wh     <= acc_sum;
      row_o.centre <= ent_q.subgraph_first;
    end
  end

  // Back-to-back row strobes only come from back-to-back single-entry row ends
  assert property (@(posedge clk) disable iff (!rst_n)
    row_vld_o && $past(row_vld_o) |->
      $past(h_vld_i && h_i.row_last, 2) && $past(h_vld_i && h_i.row_last, 3))
    else $error("spmm_row: row strobe repeated without two row ends");

endmodule

// ==== attn/attn_coef.sv ====
`timescale 1ns/1ps

module attn_coef
  import gat_pkg::*;
#(
  parameter int unsigned LEAKY_SHIFT = 3
) (
  input  logic     clk,
  input  logic     rst_n,

  input  logic     row_vld_i,
  input  wh_row_t  row_i,
  input  wgt_row_t a_self_i,
  input  wgt_row_t a_neigh_i,

  output logic     out_vld_o,
  output gat_out_t out_o
);

  function automatic coef_t dot(input wgt_row_t a, input wh_vec_t v);
    coef_t acc;
    acc = '0;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      acc = acc + coef_t'(a[k]) * coef_t'(v[k]);
    end
    return acc;
  endfunction

  // Stage 1 terms
  coef_t   self_q;
  coef_t   neigh_q;
  wh_vec_t wh_q;
  logic    vld_q;

  coef_t sum;
  coef_t coef;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= row_vld_i;
    end
  end

  // Centre term held for the rest of the subgraph
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      self_q <= '0;
    end else if (row_vld_i && row_i.centre) begin
      self_q <= dot(a_self_i, row_i.wh);
    end
  end

  always_ff @(posedge clk) begin
    if (row_vld_i) begin
      neigh_q <= dot(a_neigh_i, row_i.wh);
      wh_q    <= row_i.wh;
    end
  end

  // LeakyReLU with a power of two slope
  assign sum  = self_q + neigh_q;
  assign coef = (sum < 0) ? (sum >>> LEAKY_SHIFT) : sum;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_vld_o <= 1'b0;
    end else begin
      out_vld_o <= vld_q;
    end
  end

  always_ff @(posedge clk) begin
    if (vld_q) begin
      out_o.wh   <= wh_q;
      out_o.coef <= coef;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    out_vld_o == $past(row_vld_i, 2))
    else $error("attn_coef: output strobe not two cycles after row strobe");

endmodule

// ==== verilog/gat_conv_top.sv ====
`timescale 1ns/1ps

module gat_conv_top
  import gat_pkg::*;
#(
  parameter int unsigned LEAKY_SHIFT = 3
) (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      cfg_we_i,
  input  cfg_target_e               cfg_target_i,
  input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr_i,
  input  data_t                     cfg_data_i,

  input  logic                      h_vld_i,
  input  sparse_entry_t             h_i,

  output logic                      out_vld_o,
  output gat_out_t                  out_o
);

  wgt_row_t wgt_row;
  wgt_row_t a_self;
  wgt_row_t a_neigh;
  logic     row_vld;
  wh_row_t  row;

  weight_store u_weight_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_we_i     (cfg_we_i),
    .cfg_target_i (cfg_target_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_data_i   (cfg_data_i),
    .rd_en_i      (h_vld_i),
    .rd_col_i     (h_i.col_idx),
    .wgt_row_o    (wgt_row),
    .a_self_o     (a_self),
    .a_neigh_o    (a_neigh)
  );

  spmm_row u_spmm_row (
    .clk       (clk),
    .rst_n     (rst_n),
    .h_vld_i   (h_vld_i),
    .h_i       (h_i),
    .wgt_row_i (wgt_row),
    .row_vld_o (row_vld),
    .row_o     (row)
  );

  attn_coef #(
    .LEAKY_SHIFT (LEAKY_SHIFT)
  ) u_attn_coef (
    .clk       (clk),
    .rst_n     (rst_n),
    .row_vld_i (row_vld),
    .row_i     (row),
    .a_self_i  (a_self),
    .a_neigh_i (a_neigh),
    .out_vld_o (out_vld_o),
    .out_o     (out_o)
  );

endmodule

// ==== test/gat_model.svh ====
`ifndef GAT_MODEL_SVH
`define GAT_MODEL_SVH

// Configuration as the host wrote it
int w_model [NUM_FEATURE_IN][NUM_FEATURE_OUT];
int a_self_model [NUM_FEATURE_OUT];
int a_neigh_model [NUM_FEATURE_OUT];

// Wh of the node being streamed, and the term of the current centre node
int wh_sum [NUM_FEATURE_OUT];
int centre_term;

function automatic void add_entry(input int value, input int col);
  for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
    wh_sum[k] += value * w_model[col][k];
  end
endfunction

// Closes the node and returns its expected output
function automatic gat_out_t finish_row(input bit centre);
  gat_out_t res;
  int self_dot;
  int neigh_dot;
  int s;
  self_dot = 0;
  neigh_dot = 0;
  for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
    self_dot += a_self_model[k] * wh_sum[k];
    neigh_dot += a_neigh_model[k] * wh_sum[k];
    res.wh[k] = wh_t'(wh_sum[k]);
  end
  // A centre node uses its own Wh for the self term
  if (centre) begin
    centre_term = self_dot;
  end
  s = centre_term + neigh_dot;
  // LeakyReLU, negative side is s >>> 3
  res.coef = (s >= 0) ? coef_t'(s) : coef_t'(s >>> 3);
  for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
    wh_sum[k] = 0;
  end
  return res;
endfunction

`endif

// ==== test/gat_tb.sv ====
`timescale 1ns/1ps

module gat_tb
  import gat_pkg::*;
;

  localparam int NUM_SUBGRAPHS  = 12;
  localparam int STIM_CYCLES    = 16 + 4 + NUM_FEATURE_IN * NUM_FEATURE_OUT
                                  + 2 * NUM_FEATURE_OUT + 8 + NUM_SUBGRAPHS * 8 * 6 * 3 + 16;
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      cfg_we_i;
  cfg_target_e               cfg_target_i;
  logic [CFG_ADDR_WIDTH-1:0] cfg_addr_i;
  data_t                     cfg_data_i;
  logic                      h_vld_i;
  sparse_entry_t             h_i;
  logic                      out_vld_o;
  gat_out_t                  out_o;

  // Posedge count, each result is tagged with the count at its output edge
  int unsigned cycle = 0;
  gat_out_t    exp_q[$];
  int unsigned due_q[$];

  `include "gat_model.svh"

  gat_conv_top #(
    .LEAKY_SHIFT (3)
  ) uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_we_i     (cfg_we_i),
    .cfg_target_i (cfg_target_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_data_i   (cfg_data_i),
    .h_vld_i      (h_vld_i),
    .h_i          (h_i),
    .out_vld_o    (out_vld_o),
    .out_o        (out_o)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic check_value(input string name, input logic signed [63:0] expected,
                             input logic signed [63:0] actual);
    if (actual !== expected) begin
      $display("error: time %0t %s expected %0d got %0d", $time, name, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic write_cfg(input cfg_target_e target, input int addr, input data_t data);
    @(posedge clk);
    cfg_we_i     <= 1'b1;
    cfg_target_i <= target;
    cfg_addr_i   <= CFG_ADDR_WIDTH'(addr);
    cfg_data_i   <= data;
  endtask

  task automatic load_config();
    data_t d;
    for (int r = 0; r < NUM_FEATURE_IN; r++) begin
      for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
        d = data_t'($urandom);
        w_model[r][k] = d;
        write_cfg(CFG_WEIGHT, r * NUM_FEATURE_OUT + k, d);
      end
    end
    // a_self first, then a_neigh
    for (int i = 0; i < 2 * NUM_FEATURE_OUT; i++) begin
      d = data_t'($urandom);
      if (i < NUM_FEATURE_OUT) begin
        a_self_model[i] = d;
      end else begin
        a_neigh_model[i - NUM_FEATURE_OUT] = d;
      end
      write_cfg(CFG_ATTN, i, d);
    end
    @(posedge clk);
    cfg_we_i <= 1'b0;
  endtask

  task automatic send_entry(input sparse_entry_t ent);
    @(posedge clk);
    h_vld_i <= 1'b1;
    h_i     <= ent;
    if (ent.row_last) begin
      exp_q.push_back(finish_row(ent.subgraph_first));
      // Output is registered on the fourth edge after this one
      due_q.push_back(cycle + 5);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      h_vld_i <= 1'b0;
    end
  endtask

  // Scoreboard, sampled away from the active edge
  always @(negedge clk) begin
    gat_out_t expected;
    if (rst_n) begin
      if (due_q.size() != 0 && due_q[0] == cycle) begin
        expected = exp_q.pop_front();
        void'(due_q.pop_front());
        check_value("out_vld_o", 1, out_vld_o);
        for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
          check_value($sformatf("out_o.wh[%0d]", k), expected.wh[k], out_o.wh[k]);
        end
        check_value("out_o.coef", expected.coef, out_o.coef);
      end else begin
        check_value("out_vld_o", 0, out_vld_o);
      end
    end
  end

  initial begin
    int n_nodes;
    int n_entries;
    int gap;
    sparse_entry_t ent;

    void'($urandom(32'h2eec));
    rst_n        = 1'b0;
    cfg_we_i     = 1'b0;
    cfg_target_i = CFG_WEIGHT;
    cfg_addr_i   = '0;
    cfg_data_i   = '0;
    h_vld_i      = 1'b0;
    h_i          = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    idle_cycles(4);
    load_config();
    idle_cycles(8);

    for (int g = 0; g < NUM_SUBGRAPHS; g++) begin
      n_nodes = 2 + $urandom % 7;
      for (int n = 0; n < n_nodes; n++) begin
        n_entries = 1 + $urandom % 6;
        // Second node of the first subgraph is an all-zero row
        if (g == 0 && n == 1) begin
          n_entries = 1;
        end
        for (int e = 0; e < n_entries; e++) begin
          // Some zero values so all-zero rows show up
          ent.value          = ($urandom % 8 == 0) ? data_t'(0) : data_t'($urandom);
          ent.col_idx        = COL_IDX_WIDTH'($urandom % NUM_FEATURE_IN);
          ent.row_last       = (e == n_entries - 1);
          ent.subgraph_first = (n == 0);
          if (g == 0 && n == 1) begin
            ent.value = data_t'(0);
          end
          add_entry(ent.value, ent.col_idx);
          send_entry(ent);
          gap = $urandom % 3;
          if (gap > 0) begin
            idle_cycles(gap);
          end
        end
      end
    end
    idle_cycles(1);

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    idle_cycles(8);
    $display("PASS: all tests");
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * 10);
    $display("Timeout: results did not all arrive within %0d cycles", TIMEOUT_CYCLES);
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== verilog.f ====
+incdir+test
common/gat_pkg.sv
verilog/weight_store.sv
spmm/spmm_row.sv
attn/attn_coef.sv
verilog/gat_conv_top.sv
test/gat_tb.sv

// ==== Bender.yml ====
package:
  name: gat_conv

sources:
  - common/gat_pkg.sv
  - verilog/weight_store.sv
  - spmm/spmm_row.sv
  - attn/attn_coef.sv
  - verilog/gat_conv_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/gat_tb.sv
